// File: src.f
pipePkg.sv
regFile.sv
forwardUnit.sv
stallControl.sv
stageReg.sv
executeStage.sv
dataMem.sv
forwardPipe.sv
forwardPipe_sva.sv
tbForwardPipe.sv

// File: tbForwardPipe.sv
`timescale 1ns/1ps

module tbForwardPipe import pipePkg::*; ();

    localparam int numDirected = 17;
    localparam int numRandom   = 400;
    localparam int cycleLimit  = 8 + 3 * (numDirected + numRandom) + 50;

    logic clk;
    logic rstN;
    instT inst;
    logic ready;
    wbT   wbOut;
    brT   brOut;

    int          errCount = 0;
    int          cycles = 0;
    logic [31:0] seed = 32'd59;
    logic [31:0] refRegs [32];
    logic [31:0] refMem [64];
    wbT          wbQ [$];

    forwardPipe dut (
        .clk   (clk),
        .rstN  (rstN),
        .inst  (inst),
        .ready (ready),
        .wbOut (wbOut),
        .brOut (brOut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;
    endfunction

    // Mostly r1..r4 so neighbours collide, sometimes any register
    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        r = lcg();
        if (r[3:0] == 4'd0) begin
            return r[8:4];
        end
        return 5'd1 + r[5:4];
    endfunction

    function automatic instT randInst();
        instT        i;
        logic [31:0] r;
        r = lcg();
        i.valid = 1'b1;
        case (r % 6)
            0: i.op = opNop;
            1: i.op = opAlu;
            2: i.op = opAluImm;
            3: i.op = opLoad;
            4: i.op = opStore;
            default: i.op = opBeq;
        endcase
        i.ra1 = pickReg();
        i.ra2 = pickReg();
        i.wa  = pickReg();
        i.imm = r[16] ? r[15:0] : {10'h0, r[5:0]};
        return i;
    endfunction

    // Sequential model applied in the cycle the instruction is accepted
    task automatic modelStep(input instT i);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ext;
        logic [31:0] addr;
        logic [31:0] val;
        a    = refRegs[i.ra1];
        b    = refRegs[i.ra2];
        ext  = {{16{i.imm[15]}}, i.imm};
        addr = a + ext;
        val  = '0;
        case (i.op)
            opAlu:    val = a + b;
            opAluImm: val = a + ext;
            opLoad:   val = refMem[addr[7:2]];
            opStore:  refMem[addr[7:2]] = b;
            default: ;
        endcase
        if (i.op == opAlu || i.op == opAluImm || i.op == opLoad) begin
            wbQ.push_back('{valid: 1'b1, addr: i.wa, data: val});
            if (i.wa != 5'd0) begin
                refRegs[i.wa] = val;
            end
        end
        if (i.op == opBeq) begin
            assert (brOut.valid && brOut.taken == (a == b)) else begin
                errCount++;
                $display("error at %0t ns: brOut.taken expected %b got %b (valid %b)",
                    $time, a == b, brOut.taken, brOut.valid);
            end
        end else begin
            assert (!brOut.valid) else begin
                errCount++;
                $display("branch strobe seen for a non-branch at %0t ns", $time);
            end
        end
    endtask

    task automatic issue(input instT i, output int stalls);
        stalls = 0;
        inst = i;
        @(negedge clk);
        while (!ready) begin
            stalls++;
            @(negedge clk);
        end
        modelStep(i);
        @(posedge clk);
        #1;
    endtask

    task automatic directed(input opT op, input logic [4:0] wa, input logic [4:0] ra1,
                            input logic [4:0] ra2, input logic [15:0] imm, input int expStalls);
        int stalls;
        issue('{valid: 1'b1, op: op, ra1: ra1, ra2: ra2, wa: wa, imm: imm}, stalls);
        assert (stalls == expStalls) else begin
            errCount++;
            $display("error at %0t ns: stall cycles expected %0d got %0d",
                $time, expStalls, stalls);
        end
    endtask

    always @(negedge clk) begin
        wbT exp;
        if (rstN && wbOut.valid) begin
            if (wbQ.size() == 0) begin
                errCount++;
                $display("writeback to r%0d at %0t ns with none expected", wbOut.addr, $time);
            end else begin
                exp = wbQ.pop_front();
                assert (wbOut.addr == exp.addr && wbOut.data == exp.data) else begin
                    errCount++;
                    $display("error at %0t ns: wbOut addr/data expected %0d/%h got %0d/%h",
                        $time, exp.addr, exp.data, wbOut.addr, wbOut.data);
                end
            end
        end
    end

    initial begin
        int stalls;
        int total;
        inst = '0;
        rstN = 1'b0;
        for (int k = 0; k < 32; k++) refRegs[k] = '0;
        for (int k = 0; k < 64; k++) refMem[k] = '0;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (ready && !wbOut.valid && !brOut.valid) else begin
                errCount++;
                $display("pipeline not idle after reset at %0t ns", $time);
            end
        end
        @(posedge clk);
        #1;
        // Distances 1, 2 and 3, then load-use, branch stalls and r0
        directed(opAluImm, 5'd1, 5'd0, 5'd0, 16'd5, 0);
        directed(opAluImm, 5'd2, 5'd0, 5'd0, 16'd7, 0);
        directed(opAlu, 5'd3, 5'd1, 5'd2, 16'd0, 0);
        directed(opAlu, 5'd4, 5'd3, 5'd3, 16'd0, 0);
        directed(opAlu, 5'd5, 5'd2, 5'd4, 16'd0, 0);
        directed(opStore, 5'd0, 5'd0, 5'd5, 16'd8, 0);
        directed(opLoad, 5'd6, 5'd0, 5'd0, 16'd8, 0);
        directed(opAlu, 5'd7, 5'd6, 5'd1, 16'd0, 1);
        directed(opLoad, 5'd8, 5'd0, 5'd0, 16'd8, 0);
        directed(opStore, 5'd0, 5'd0, 5'd8, 16'd12, 1);
        directed(opAluImm, 5'd9, 5'd0, 5'd0, 16'hfffd, 0);
        directed(opBeq, 5'd0, 5'd9, 5'd9, 16'd0, 1);
        directed(opLoad, 5'd10, 5'd0, 5'd0, 16'd8, 0);
        directed(opBeq, 5'd0, 5'd10, 5'd5, 16'd0, 2);
        directed(opBeq, 5'd0, 5'd1, 5'd2, 16'd0, 0);
        directed(opAluImm, 5'd0, 5'd0, 5'd0, 16'd99, 0);
        directed(opAlu, 5'd11, 5'd0, 5'd0, 16'd0, 0);
        for (int n = 0; n < numRandom; n++) begin
            issue(randInst(), stalls);
        end
        inst = '0;
        repeat (6) @(posedge clk);
        assert (wbQ.size() == 0) else begin
            errCount++;
            $display("%0d expected writebacks never appeared", wbQ.size());
        end
        total = errCount + dut.checks.failCount;
        $display("errors: %0d testbench, %0d assertion", errCount, dut.checks.failCount);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: forwardPipe_sva.sv
`timescale 1ns/1ps

module forwardPipeChecks import pipePkg::*; (
    input logic clk,
    input logic rstN,
    input instT inst,
    input logic ready,
    input logic bubble,
    input wbT   wbOut,
    input brT   brOut
);

    int   failCount = 0;
    logic accWriter;

    assign accWriter = inst.valid && ready && (inst.op inside {opAlu, opAluImm, opLoad});

    // Only a branch behind a load may wait a second cycle
    stallOne: assert property (@(posedge clk) disable iff (!rstN)
        (!ready && inst.op != opBeq) |=> ready)
        else begin
            failCount++;
            $error("non-branch stall lasted more than one cycle");
        end

    stallTwo: assert property (@(posedge clk) disable iff (!rstN)
        (!ready ##1 !ready) |=> ready)
        else begin
            failCount++;
            $error("stall lasted more than two cycles");
        end

    // Bubble reaches WB three advances later
    bubbleQuiet: assert property (@(posedge clk) disable iff (!rstN)
        bubble |-> ##3 !wbOut.valid)
        else begin
            failCount++;
            $error("bubble produced a writeback");
        end

    wbLatency: assert property (@(posedge clk) disable iff (!rstN)
        accWriter |-> ##3 wbOut.valid)
        else begin
            failCount++;
            $error("accepted writer gave no writeback three cycles later");
        end

    wbSource: assert property (@(posedge clk) disable iff (!rstN)
        wbOut.valid |-> $past(accWriter, 3))
        else begin
            failCount++;
            $error("writeback without a writer accepted three cycles earlier");
        end

    resetQuiet: assert property (@(posedge clk)
        $rose(rstN) |-> (ready && !wbOut.valid && !brOut.valid))
        else begin
            failCount++;
            $error("pipeline not idle when reset released");
        end

endmodule

bind forwardPipe forwardPipeChecks checks (.*);

// File: forwardPipe.sv
`timescale 1ns/1ps

module forwardPipe import pipePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  instT inst,
    output logic ready,
    output wbT   wbOut,
    output brT   brOut
);

    logic [dataW-1:0] rd1;
    logic [dataW-1:0] rd2;
    fwdT              fwdA;
    fwdT              fwdB;
    fwdT              fwdSw;
    logic             hazard;
    logic             bubble;

    idExT  idExD;
    idExT  idExQ;
    exMemT exMemD;
    exMemT exMemQ;
    memWbT memWbD;
    memWbT memWbQ;

    regFile regs (
        .clk  (clk),
        .rstN (rstN),
        .ra1  (inst.ra1),
        .ra2  (inst.ra2),
        .wr   (wbOut),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    forwardUnit fwd (
        .inst     (inst),
        .exStage  (idExQ),
        .memStage (exMemQ),
        .rd1      (rd1),
        .rd2      (rd2),
        .memFwd   (exMemQ.aluResult),
        .wbFwd    (wbOut),
        .fwdA     (fwdA),
        .fwdB     (fwdB),
        .fwdSw    (fwdSw),
        .brFwdA   (),
        .brFwdB   (),
        .hazard   (hazard),
        .brOut    (brOut)
    );

    stallControl stallCtl (
        .clk    (clk),
        .rstN   (rstN),
        .hazard (hazard),
        .ready  (ready),
        .bubble (bubble)
    );

    // ID/EX payload
    assign idExD = '{
        valid: inst.valid,
        op:    inst.op,
        wa:    inst.wa,
        rd1:   rd1,
        rd2:   rd2,
        imm:   signExt(inst.imm),
        fwdA:  fwdA,
        fwdB:  fwdB,
        fwdSw: fwdSw
    };

    stageReg #(.payloadT(idExT)) idEx (
        .clk(clk), .rstN(rstN), .flush(bubble), .d(idExD), .q(idExQ)
    );

    executeStage exec (
        .ex     (idExQ),
        .memFwd (exMemQ.aluResult),
        .wbFwd  (memWbQ.data),
        .out    (exMemD)
    );

    stageReg #(.payloadT(exMemT)) exMem (
        .clk(clk), .rstN(rstN), .flush(1'b0), .d(exMemD), .q(exMemQ)
    );

    dataMem dmem (
        .clk  (clk),
        .rstN (rstN),
        .mem  (exMemQ),
        .wb   (memWbD)
    );

    stageReg #(.payloadT(memWbT)) memWb (
        .clk(clk), .rstN(rstN), .flush(1'b0), .d(memWbD), .q(memWbQ)
    );

    assign wbOut.valid = memWbQ.valid && memWbQ.regWrite;
    assign wbOut.addr  = memWbQ.wa;
    assign wbOut.data  = memWbQ.data;

endmodule

// File: dataMem.sv
`timescale 1ns/1ps

module dataMem import pipePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  exMemT mem,
    output memWbT wb
);

    logic [dataW-1:0]    words [memWords];
    logic [memAddrW-1:0] wordAddr;

    // Word address from the byte address
    assign wordAddr = mem.aluResult[memAddrW+1:2];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < memWords; i++) begin
                words[i] <= '0;
            end
        end else if (mem.valid && mem.op == opStore) begin
            words[wordAddr] <= mem.storeData;
        end
    end

    assign wb.valid    = mem.valid;
    assign wb.regWrite = mem.valid && isWriter(mem.op);
    assign wb.wa       = mem.wa;
    assign wb.data     = (mem.op == opLoad) ? words[wordAddr] : mem.aluResult;

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage import pipePkg::*; (
    input  idExT             ex,
    input  logic [dataW-1:0] memFwd,
    input  logic [dataW-1:0] wbFwd,
    output exMemT            out
);

    logic [dataW-1:0] opA;
    logic [dataW-1:0] regB;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] storeVal;
    logic             useImm;

    function automatic logic [dataW-1:0] pick(
        fwdT              code,
        logic [dataW-1:0] regVal,
        logic [dataW-1:0] memVal,
        logic [dataW-1:0] wbVal
    );
        case (code)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            // Stall codes never reach EX
            default: return regVal;
        endcase
    endfunction

    assign useImm = (ex.op == opAluImm) || (ex.op == opLoad) || (ex.op == opStore);

    assign opA      = pick(ex.fwdA, ex.rd1, memFwd, wbFwd);
    assign regB     = pick(ex.fwdB, ex.rd2, memFwd, wbFwd);
    assign storeVal = pick(ex.fwdSw, ex.rd2, memFwd, wbFwd);
    assign opB      = useImm ? ex.imm : regB;

    assign out.valid     = ex.valid;
    assign out.op        = ex.op;
    assign out.wa        = ex.wa;
    assign out.aluResult = opA + opB;
    assign out.storeData = storeVal;

endmodule

// File: stageReg.sv
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // All-zero payload is a bubble with valid low
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// File: stallControl.sv
`timescale 1ns/1ps

module stallControl (
    input  logic clk,
    input  logic rstN,
    input  logic hazard,
    output logic ready,
    output logic bubble
);

    typedef enum logic {
        stRun   = 1'b0,
        stStall = 1'b1
    } stateT;

    stateT state;
    stateT nextState;

    always_comb begin
        nextState = state;
        case (state)
            stRun: begin
                if (hazard) begin
                    nextState = stStall;
                end
            end
            stStall: begin
                // Every hazard clears after a fixed number of advances
                if (!hazard) begin
                    nextState = stRun;
                end
            end
            default: begin
                nextState = stRun;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stRun;
        end else begin
            state <= nextState;
        end
    end

    // Decoded from next state so issue is held in the hazard cycle itself
    assign ready  = nextState == stRun;
    assign bubble = nextState == stStall;

endmodule

// File: forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit import pipePkg::*; (
    input  instT             inst,
    input  idExT             exStage,
    input  exMemT            memStage,
    input  logic [dataW-1:0] rd1,
    input  logic [dataW-1:0] rd2,
    input  logic [dataW-1:0] memFwd,
    input  wbT               wbFwd,
    output fwdT              fwdA,
    output fwdT              fwdB,
    output fwdT              fwdSw,
    output fwdT              brFwdA,
    output fwdT              brFwdB,
    output logic             hazard,
    output brT               brOut
);

    logic exWr, memWr, wbWr;
    logic exLoad, memLoad;
    logic exHit1, exHit2, memHit1, memHit2, wbHit1, wbHit2;
    logic [dataW-1:0] brA, brB;

    // Codes as seen from EX one cycle after issue
    function automatic fwdT aluCode(logic inEx, logic exIsLoad, logic inMem);
        if (inEx) begin
            return exIsLoad ? fwdStall : fwdMem;
        end
        if (inMem) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    // Branch resolves in ID, so an EX writer is still too far away
    function automatic fwdT brCode(logic inEx, logic inMem, logic memIsLoad, logic inWb);
        if (inEx) begin
            return fwdStall;
        end
        if (inMem) begin
            return memIsLoad ? fwdStall : fwdMem;
        end
        if (inWb) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign exWr    = exStage.valid && isWriter(exStage.op) && exStage.wa != '0;
    assign memWr   = memStage.valid && isWriter(memStage.op) && memStage.wa != '0;
    assign wbWr    = wbFwd.valid && wbFwd.addr != '0;
    assign exLoad  = exStage.op == opLoad;
    assign memLoad = memStage.op == opLoad;

    assign exHit1  = exWr && exStage.wa == inst.ra1;
    assign exHit2  = exWr && exStage.wa == inst.ra2;
    assign memHit1 = memWr && memStage.wa == inst.ra1;
    assign memHit2 = memWr && memStage.wa == inst.ra2;
    assign wbHit1  = wbWr && wbFwd.addr == inst.ra1;
    assign wbHit2  = wbWr && wbFwd.addr == inst.ra2;

    always_comb begin
        fwdA   = fwdReg;
        fwdB   = fwdReg;
        fwdSw  = fwdReg;
        brFwdA = fwdReg;
        brFwdB = fwdReg;
        if (inst.valid) begin
            case (inst.op)
                opAlu: begin
                    fwdA = aluCode(exHit1, exLoad, memHit1);
                    fwdB = aluCode(exHit2, exLoad, memHit2);
                end
                opAluImm, opLoad: begin
                    fwdA = aluCode(exHit1, exLoad, memHit1);
                end
                opStore: begin
                    fwdA  = aluCode(exHit1, exLoad, memHit1);
                    fwdSw = aluCode(exHit2, exLoad, memHit2);
                end
                opBeq: begin
                    brFwdA = brCode(exHit1, memHit1, memLoad, wbHit1);
                    brFwdB = brCode(exHit2, memHit2, memLoad, wbHit2);
                end
                default: ;
            endcase
        end
    end

    assign hazard = (fwdA == fwdStall) || (fwdB == fwdStall) || (fwdSw == fwdStall) ||
                    (brFwdA == fwdStall) || (brFwdB == fwdStall);

    always_comb begin
        case (brFwdA)
            fwdMem:  brA = memFwd;
            fwdWb:   brA = wbFwd.data;
            default: brA = rd1;
        endcase
        case (brFwdB)
            fwdMem:  brB = memFwd;
            fwdWb:   brB = wbFwd.data;
            default: brB = rd2;
        endcase
    end

    assign brOut.valid = inst.valid && inst.op == opBeq && !hazard;
    assign brOut.taken = brOut.valid && (brA == brB);

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile import pipePkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic [regAddrW-1:0] ra1,
    input  logic [regAddrW-1:0] ra2,
    input  wbT                  wr,
    output logic [dataW-1:0]    rd1,
    output logic [dataW-1:0]    rd2
);

    logic [dataW-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Write-through so a WB writer needs no forward path
    always_comb begin
        rd1 = regs[ra1];
        if (ra1 == '0) begin
            rd1 = '0;
        end else if (wr.valid && wr.addr == ra1) begin
            rd1 = wr.data;
        end

        rd2 = regs[ra2];
        if (ra2 == '0) begin
            rd2 = '0;
        end else if (wr.valid && wr.addr == ra2) begin
            rd2 = wr.data;
        end
    end

endmodule

// File: pipePkg.sv
package pipePkg;

    localparam int regAddrW = 5;
    localparam int dataW    = 32;
    localparam int memWords = 64;
    localparam int immW     = 16;
    localparam int regCount = 1 << regAddrW;
    localparam int memAddrW = $clog2(memWords);

    typedef enum logic [2:0] {
        opNop    = 3'd0,
        opAlu    = 3'd1,
        opAluImm = 3'd2,
        opLoad   = 3'd3,
        opStore  = 3'd4,
        opBeq    = 3'd5
    } opT;

    // Operand source select for the forwarding muxes
    typedef enum logic [1:0] {
        fwdReg   = 2'b00,
        fwdMem   = 2'b01,
        fwdWb    = 2'b10,
        fwdStall = 2'b11
    } fwdT;

    typedef struct packed {
        logic                valid;
        opT                  op;
        logic [regAddrW-1:0] ra1;
        logic [regAddrW-1:0] ra2;
        logic [regAddrW-1:0] wa;
        logic [immW-1:0]     imm;
    } instT;

    typedef struct packed {
        logic                valid;
        opT                  op;
        logic [regAddrW-1:0] wa;
        logic [dataW-1:0]    rd1;
        logic [dataW-1:0]    rd2;
        logic [dataW-1:0]    imm;
        fwdT                 fwdA;
        fwdT                 fwdB;
        fwdT                 fwdSw;
    } idExT;

    typedef struct packed {
        logic                valid;
        opT                  op;
        logic [regAddrW-1:0] wa;
        logic [dataW-1:0]    aluResult;
        logic [dataW-1:0]    storeData;
    } exMemT;

    typedef struct packed {
        logic                valid;
        logic                regWrite;
        logic [regAddrW-1:0] wa;
        logic [dataW-1:0]    data;
    } memWbT;

    typedef struct packed {
        logic                valid;
        logic [regAddrW-1:0] addr;
        logic [dataW-1:0]    data;
    } wbT;

    typedef struct packed {
        logic valid;
        logic taken;
    } brT;

    // Ops that produce a register result
    function automatic logic isWriter(opT op);
        return (op == opAlu) || (op == opAluImm) || (op == opLoad);
    endfunction

    function automatic logic [dataW-1:0] signExt(logic [immW-1:0] imm);
        return {{(dataW - immW){imm[immW-1]}}, imm};
    endfunction

endpackage
